// File: shell_pkg.sv
package shell_pkg;

    // ------------------------------------------------------------------------
    // External memory port
    // ------------------------------------------------------------------------
    localparam int addr_w = 28;
    localparam int data_w = 64;
    localparam int strb_w = data_w / 8;

    // Voxel debug window at the bottom of the address space
    localparam logic [addr_w-1:0] voxel_win_base  = 28'h000_0000;
    localparam logic [addr_w-1:0] voxel_win_bytes = 28'h004_0000;
    localparam int voxel_words = 32768;
    // Word index comes from byte address bits 17:3
    localparam int voxel_idx_w = 15;

    // Memory window at the BAR1 base
    localparam logic [addr_w-1:0] mem_base  = 28'h100_0000;
    localparam logic [addr_w-1:0] mem_bytes = 28'h001_0000;
    localparam int mem_words = 8192;
    localparam int mem_idx_w = 13;

    // ------------------------------------------------------------------------
    // Pixel stream
    // ------------------------------------------------------------------------
    localparam int screen_width  = 480;
    localparam int screen_height = 360;
    localparam int total_pixels  = screen_width * screen_height;
    localparam int pix_addr_w    = 18;
    localparam int rgb_w         = 24;

    localparam int count_w       = 32;
    localparam int short_count_w = 16;

    // Response codes, AXI encoding
    typedef enum logic [1:0] {
        resp_okay   = 2'b00,
        resp_slverr = 2'b10
    } resp_e;

    // Address decode result
    typedef enum logic [1:0] {
        region_voxel = 2'd0,
        region_mem   = 2'd1,
        region_none  = 2'd2
    } region_e;

endpackage

// File: mem_stub.sv
`timescale 1ns/1ps

// Block-RAM stand-in for external memory behind the BAR1 window
module mem_stub (
    input  logic                            clk,
    input  logic                            mem_we,
    input  logic                            mem_re,
    input  logic [shell_pkg::mem_idx_w-1:0] mem_idx,
    input  logic [shell_pkg::data_w-1:0]    mem_wdata,
    input  logic [shell_pkg::strb_w-1:0]    mem_strb,
    output logic [shell_pkg::data_w-1:0]    mem_rdata
);

    // ------------------------------------------------------------------------
    // Storage
    // ------------------------------------------------------------------------
    logic [shell_pkg::data_w-1:0] ram [shell_pkg::mem_words];

    // One enable per byte lane
    always_ff @(posedge clk) begin
        if (mem_we) begin
            for (int b = 0; b < shell_pkg::strb_w; b++) begin
                if (mem_strb[b])
                    ram[mem_idx][b*8 +: 8] <= mem_wdata[b*8 +: 8];
            end
        end
    end

    // ------------------------------------------------------------------------
    // Registered read
    // ------------------------------------------------------------------------

    // Holds the last read word until the next read strobe
    always_ff @(posedge clk) begin
        if (mem_re)
            mem_rdata <= ram[mem_idx];
    end

endmodule

// File: voxel_window_store.sv
`timescale 1ns/1ps

// Stand-in for the renderer's voxel map. The debug window writes whole
// words and reads them back through a registered port.
module voxel_window_store (
    input  logic                              clk,
    input  logic                              vox_we,
    input  logic                              vox_re,
    input  logic [shell_pkg::voxel_idx_w-1:0] vox_idx,
    input  logic [shell_pkg::data_w-1:0]      vox_wdata,
    output logic [shell_pkg::data_w-1:0]      vox_rdata
);

    // ------------------------------------------------------------------------
    // Word array
    // ------------------------------------------------------------------------
    logic [shell_pkg::data_w-1:0] voxel_mem [shell_pkg::voxel_words];

    // Strobes are not applied on this path, a write replaces the full word
    always_ff @(posedge clk) begin
        if (vox_we)
            voxel_mem[vox_idx] <= vox_wdata;
    end

    // ------------------------------------------------------------------------
    // Read port
    // ------------------------------------------------------------------------

    // Output only moves on a read strobe, so the word stays put
    // while the response waits for r_ready
    always_ff @(posedge clk) begin
        if (vox_re)
            vox_rdata <= voxel_mem[vox_idx];
    end

endmodule

// File: ext_port_router.sv
`timescale 1ns/1ps

module ext_port_router (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic                              wr_valid,
    output logic                              wr_ready,
    input  logic [shell_pkg::addr_w-1:0]      wr_addr,
    input  logic [shell_pkg::data_w-1:0]      wr_data,
    input  logic [shell_pkg::strb_w-1:0]      wr_strb,
    output logic                              b_valid,
    input  logic                              b_ready,
    output shell_pkg::resp_e                  b_resp,
    input  logic                              rd_valid,
    output logic                              rd_ready,
    input  logic [shell_pkg::addr_w-1:0]      rd_addr,
    output logic                              r_valid,
    input  logic                              r_ready,
    output logic [shell_pkg::data_w-1:0]      r_data,
    output shell_pkg::resp_e                  r_resp,
    output logic                              vox_we,
    output logic                              vox_re,
    output logic [shell_pkg::voxel_idx_w-1:0] vox_idx,
    output logic [shell_pkg::data_w-1:0]      vox_wdata,
    input  logic [shell_pkg::data_w-1:0]      vox_rdata,
    output logic                              mem_we,
    output logic                              mem_re,
    output logic [shell_pkg::mem_idx_w-1:0]   mem_idx,
    output logic [shell_pkg::data_w-1:0]      mem_wdata,
    output logic [shell_pkg::strb_w-1:0]      mem_strb,
    input  logic [shell_pkg::data_w-1:0]      mem_rdata
);

    // Offsets wrap below the base, so one compare covers both bounds
    function automatic shell_pkg::region_e decode(
        input logic [shell_pkg::addr_w-1:0] vox_off,
        input logic [shell_pkg::addr_w-1:0] mem_off
    );
        if (vox_off < shell_pkg::voxel_win_bytes)
            return shell_pkg::region_voxel;
        else if (mem_off < shell_pkg::mem_bytes)
            return shell_pkg::region_mem;
        else
            return shell_pkg::region_none;
    endfunction

    logic [shell_pkg::addr_w-1:0] wr_vox_off, wr_mem_off;
    logic [shell_pkg::addr_w-1:0] rd_vox_off, rd_mem_off;
    shell_pkg::region_e           wr_region, rd_region, rd_region_q;
    logic                         wr_fire, rd_fire, rd_blocked;

    assign wr_vox_off = wr_addr - shell_pkg::voxel_win_base;
    assign wr_mem_off = wr_addr - shell_pkg::mem_base;
    assign rd_vox_off = rd_addr - shell_pkg::voxel_win_base;
    assign rd_mem_off = rd_addr - shell_pkg::mem_base;
    assign wr_region  = decode(wr_vox_off, wr_mem_off);
    assign rd_region  = decode(rd_vox_off, rd_mem_off);

    // A target has a single index port, so a read waits out a write to it
    assign rd_blocked = wr_valid && wr_ready && (rd_region == wr_region) &&
                        (rd_region != shell_pkg::region_none);
    assign wr_ready   = !b_valid;
    assign rd_ready   = !r_valid && !rd_blocked;
    assign wr_fire    = wr_valid && wr_ready;
    assign rd_fire    = rd_valid && rd_ready;

    // ------------------------------------------------------------------------
    // Target strobes, issued on the accepting edge
    // ------------------------------------------------------------------------
    assign vox_we    = wr_fire && (wr_region == shell_pkg::region_voxel);
    assign vox_re    = rd_fire && (rd_region == shell_pkg::region_voxel);
    assign vox_idx   = vox_we ? wr_vox_off[shell_pkg::voxel_idx_w+2:3]
                              : rd_vox_off[shell_pkg::voxel_idx_w+2:3];
    assign vox_wdata = wr_data;

    assign mem_we    = wr_fire && (wr_region == shell_pkg::region_mem);
    assign mem_re    = rd_fire && (rd_region == shell_pkg::region_mem);
    assign mem_idx   = mem_we ? wr_mem_off[shell_pkg::mem_idx_w+2:3]
                              : rd_mem_off[shell_pkg::mem_idx_w+2:3];
    assign mem_wdata = wr_data;
    assign mem_strb  = wr_strb;

    // ------------------------------------------------------------------------
    // Response handshakes
    // ------------------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            b_valid     <= 1'b0;
            r_valid     <= 1'b0;
            rd_region_q <= shell_pkg::region_none;
        end else begin
            if (wr_fire)
                b_valid <= 1'b1;
            else if (b_ready)
                b_valid <= 1'b0;
            if (rd_fire) begin
                r_valid     <= 1'b1;
                rd_region_q <= rd_region;
            end else if (r_ready) begin
                r_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr_fire)
            b_resp <= (wr_region == shell_pkg::region_none) ? shell_pkg::resp_slverr
                                                             : shell_pkg::resp_okay;
    end

    // Target read word is already registered one cycle after the strobe
    assign r_resp = (rd_region_q == shell_pkg::region_none) ? shell_pkg::resp_slverr
                                                             : shell_pkg::resp_okay;
    always_comb begin
        case (rd_region_q)
            shell_pkg::region_voxel: r_data = vox_rdata;
            shell_pkg::region_mem:   r_data = mem_rdata;
            default:                 r_data = '0;
        endcase
    end

endmodule

// File: pixel_stream_monitor.sv
`timescale 1ns/1ps

module pixel_stream_monitor (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic                                pix_valid,
    output logic                                pix_ready,
    input  logic [shell_pkg::pix_addr_w-1:0]    pix_addr,
    input  logic [shell_pkg::rgb_w-1:0]         pix_rgb,
    output logic [shell_pkg::rgb_w-1:0]         tdata,
    output logic                                tvalid,
    output logic                                tuser,
    output logic                                tlast,
    input  logic                                tready,
    output logic [shell_pkg::count_w-1:0]       beat_count,
    output logic [shell_pkg::count_w-1:0]       frame_count,
    output logic [shell_pkg::short_count_w-1:0] line_count,
    output logic [shell_pkg::short_count_w-1:0] pixel_in_line
);

    logic beat_ok;

    // ------------------------------------------------------------------------
    // Framing, straight through with no pipeline stage
    // ------------------------------------------------------------------------
    assign pix_ready = tready;
    assign tdata     = pix_rgb;
    assign tvalid    = pix_valid;
    assign tuser     = (pix_addr == shell_pkg::pix_addr_w'(0));
    assign tlast     = (pix_addr == shell_pkg::pix_addr_w'(shell_pkg::total_pixels - 1));
    assign beat_ok   = tvalid && tready;

    // ------------------------------------------------------------------------
    // Statistics
    // ------------------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            beat_count    <= '0;
            frame_count   <= '0;
            line_count    <= '0;
            pixel_in_line <= '0;
        end else if (beat_ok) begin
            beat_count <= beat_count + 1'b1;
            if (tuser) begin
                // Start of frame counts as the first pixel of line 0
                pixel_in_line <= shell_pkg::short_count_w'(1);
                line_count    <= '0;
            end else if (pixel_in_line ==
                         shell_pkg::short_count_w'(shell_pkg::screen_width - 1)) begin
                pixel_in_line <= '0;
                line_count    <= line_count + 1'b1;
            end else begin
                pixel_in_line <= pixel_in_line + 1'b1;
            end
            if (tlast)
                frame_count <= frame_count + 1'b1;
        end
    end

endmodule

// File: voxel_shell_top.sv
`timescale 1ns/1ps

module voxel_shell_top (
    input  logic                               clk,
    input  logic                               rst_n,

    // Write channel
    input  logic                               wr_valid,
    output logic                               wr_ready,
    input  logic [shell_pkg::addr_w-1:0]       wr_addr,
    input  logic [shell_pkg::data_w-1:0]       wr_data,
    input  logic [shell_pkg::strb_w-1:0]       wr_strb,

    // Write response
    output logic                               b_valid,
    input  logic                               b_ready,
    output shell_pkg::resp_e                   b_resp,

    // Read channel
    input  logic                               rd_valid,
    output logic                               rd_ready,
    input  logic [shell_pkg::addr_w-1:0]       rd_addr,

    // Read response
    output logic                               r_valid,
    input  logic                               r_ready,
    output logic [shell_pkg::data_w-1:0]       r_data,
    output shell_pkg::resp_e                   r_resp,

    // Pixel input
    input  logic                               pix_valid,
    output logic                               pix_ready,
    input  logic [shell_pkg::pix_addr_w-1:0]   pix_addr,
    input  logic [shell_pkg::rgb_w-1:0]        pix_rgb,

    // Pixel stream out
    output logic [shell_pkg::rgb_w-1:0]        tdata,
    output logic                               tvalid,
    output logic                               tuser,
    output logic                               tlast,
    input  logic                               tready,

    // Stream statistics
    output logic [shell_pkg::count_w-1:0]       beat_count,
    output logic [shell_pkg::count_w-1:0]       frame_count,
    output logic [shell_pkg::short_count_w-1:0] line_count,
    output logic [shell_pkg::short_count_w-1:0] pixel_in_line
);

    // ------------------------------------------------------------------------
    // Router to voxel store and memory stub
    // ------------------------------------------------------------------------
    logic                              vox_we;
    logic                              vox_re;
    logic [shell_pkg::voxel_idx_w-1:0] vox_idx;
    logic [shell_pkg::data_w-1:0]      vox_wdata;
    logic [shell_pkg::data_w-1:0]      vox_rdata;

    logic                              mem_we;
    logic                              mem_re;
    logic [shell_pkg::mem_idx_w-1:0]   mem_idx;
    logic [shell_pkg::data_w-1:0]      mem_wdata;
    logic [shell_pkg::strb_w-1:0]      mem_strb;
    logic [shell_pkg::data_w-1:0]      mem_rdata;

    ext_port_router router_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .wr_valid  (wr_valid),
        .wr_ready  (wr_ready),
        .wr_addr   (wr_addr),
        .wr_data   (wr_data),
        .wr_strb   (wr_strb),
        .b_valid   (b_valid),
        .b_ready   (b_ready),
        .b_resp    (b_resp),
        .rd_valid  (rd_valid),
        .rd_ready  (rd_ready),
        .rd_addr   (rd_addr),
        .r_valid   (r_valid),
        .r_ready   (r_ready),
        .r_data    (r_data),
        .r_resp    (r_resp),
        .vox_we    (vox_we),
        .vox_re    (vox_re),
        .vox_idx   (vox_idx),
        .vox_wdata (vox_wdata),
        .vox_rdata (vox_rdata),
        .mem_we    (mem_we),
        .mem_re    (mem_re),
        .mem_idx   (mem_idx),
        .mem_wdata (mem_wdata),
        .mem_strb  (mem_strb),
        .mem_rdata (mem_rdata)
    );

    voxel_window_store store_i (
        .clk       (clk),
        .vox_we    (vox_we),
        .vox_re    (vox_re),
        .vox_idx   (vox_idx),
        .vox_wdata (vox_wdata),
        .vox_rdata (vox_rdata)
    );

    mem_stub mem_i (
        .clk       (clk),
        .mem_we    (mem_we),
        .mem_re    (mem_re),
        .mem_idx   (mem_idx),
        .mem_wdata (mem_wdata),
        .mem_strb  (mem_strb),
        .mem_rdata (mem_rdata)
    );

    // ------------------------------------------------------------------------
    // Pixel side
    // ------------------------------------------------------------------------
    pixel_stream_monitor monitor_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .pix_valid     (pix_valid),
        .pix_ready     (pix_ready),
        .pix_addr      (pix_addr),
        .pix_rgb       (pix_rgb),
        .tdata         (tdata),
        .tvalid        (tvalid),
        .tuser         (tuser),
        .tlast         (tlast),
        .tready        (tready),
        .beat_count    (beat_count),
        .frame_count   (frame_count),
        .line_count    (line_count),
        .pixel_in_line (pixel_in_line)
    );

endmodule

// File: voxel_shell_props.sv
`timescale 1ns/1ps

// Handshake rules on the external port, bound into the router
module voxel_shell_props (
    input logic clk,
    input logic rst_n,
    input logic wr_valid,
    input logic wr_ready,
    input logic b_valid,
    input logic b_ready,
    input logic r_valid,
    input logic r_ready
);

    // Number of assertion failures so far
    int fail_count = 0;

    b_valid_held: assert property (@(posedge clk) disable iff (!rst_n)
        b_valid && !b_ready |=> b_valid)
        else begin
            $error("b_valid dropped before b_ready was seen");
            fail_count++;
        end

    r_valid_held: assert property (@(posedge clk) disable iff (!rst_n)
        r_valid && !r_ready |=> r_valid)
        else begin
            $error("r_valid dropped before r_ready was seen");
            fail_count++;
        end

    // Only one write may be outstanding
    wr_blocked: assert property (@(posedge clk) disable iff (!rst_n)
        wr_valid && wr_ready |=> b_valid && !wr_ready)
        else begin
            $error("accepted write did not raise b_valid and close wr_ready");
            fail_count++;
        end

endmodule

bind ext_port_router voxel_shell_props props_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .wr_valid (wr_valid),
    .wr_ready (wr_ready),
    .b_valid  (b_valid),
    .b_ready  (b_ready),
    .r_valid  (r_valid),
    .r_ready  (r_ready)
);

// File: voxel_shell_tb.sv
`timescale 1ns/1ps

module voxel_shell_tb;

    // Rough cycle cost of each test, summed for the watchdog
    localparam int test_cycles = 16 * 9 + 16 * 6 + 24 + 45 + 2002 + 3 * 60;

    logic                                clk;
    logic                                rst_n;
    logic                                wr_valid, wr_ready, b_valid, b_ready;
    logic                                rd_valid, rd_ready, r_valid, r_ready;
    logic [shell_pkg::addr_w-1:0]        wr_addr, rd_addr;
    logic [shell_pkg::data_w-1:0]        wr_data, r_data;
    logic [shell_pkg::strb_w-1:0]        wr_strb;
    shell_pkg::resp_e                    b_resp, r_resp;
    logic                                pix_valid, pix_ready, tvalid, tuser, tlast, tready;
    logic [shell_pkg::pix_addr_w-1:0]    pix_addr;
    logic [shell_pkg::rgb_w-1:0]         pix_rgb, tdata;
    logic [shell_pkg::count_w-1:0]       beat_count, frame_count;
    logic [shell_pkg::short_count_w-1:0] line_count, pixel_in_line;

    int errors;
    int read_stall;
    bit stall_stream;
    // Reference contents of the memory window and expected stream counters
    logic [shell_pkg::data_w-1:0] mem_model [shell_pkg::mem_words];
    int used_idx [$];
    int exp_beats, exp_frames, exp_lines, exp_pil;

    voxel_shell_top dut_i (.*);

    initial clk = 1'b0;
    always #5 clk = ~clk;

    // ------------------------------------------------------------------------
    // Compare tasks
    // ------------------------------------------------------------------------
    task automatic check_data(input logic [shell_pkg::data_w-1:0] got, exp, input string what);
        if (got !== exp) begin
            errors++;
            $display("** Error at %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_resp(input shell_pkg::resp_e got, exp, input string what);
        if (got !== exp) begin
            errors++;
            $display("** Error at %0t: %s is %s, expected %s", $time, what, got.name(),
                     exp.name());
        end
    endtask

    task automatic check_count(input logic [shell_pkg::count_w-1:0] got, exp, input string what);
        if (got !== exp) begin
            errors++;
            $display("** Error at %0t: %s is %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic report_failure(input string msg);
        errors++;
        $display("Failure at %0t: %s", $time, msg);
    endtask

    // ------------------------------------------------------------------------
    // External port transfers
    // ------------------------------------------------------------------------
    task automatic drive_write(input logic [shell_pkg::addr_w-1:0] addr,
                               input logic [shell_pkg::data_w-1:0] data,
                               input logic [shell_pkg::strb_w-1:0] strb);
        wr_valid <= 1'b1;
        wr_addr  <= addr;
        wr_data  <= data;
        wr_strb  <= strb;
    endtask

    task automatic wait_write_accept;
        do @(posedge clk); while (!wr_ready);
        wr_valid <= 1'b0;
    endtask

    task automatic wait_bresp(output shell_pkg::resp_e resp);
        do @(posedge clk); while (!(b_valid && b_ready));
        resp = b_resp;
    endtask

    task automatic do_write(input logic [shell_pkg::addr_w-1:0] addr,
                            input logic [shell_pkg::data_w-1:0] data,
                            input logic [shell_pkg::strb_w-1:0] strb,
                            output shell_pkg::resp_e resp);
        drive_write(addr, data, strb);
        wait_write_accept();
        wait_bresp(resp);
    endtask

    task automatic do_read(input logic [shell_pkg::addr_w-1:0] addr,
                           output logic [shell_pkg::data_w-1:0] data,
                           output shell_pkg::resp_e resp);
        rd_valid <= 1'b1;
        rd_addr  <= addr;
        do @(posedge clk); while (!rd_ready);
        rd_valid <= 1'b0;
        // Optional hold-off on r_ready while the response waits
        if (read_stall > 0) begin
            r_ready <= 1'b0;
            repeat (read_stall) begin
                @(posedge clk);
                if (!r_valid)
                    report_failure("read response not held while r_ready was low");
            end
            r_ready <= 1'b1;
        end
        do @(posedge clk); while (!(r_valid && r_ready));
        data = r_data;
        resp = r_resp;
    endtask

    function automatic logic [shell_pkg::data_w-1:0] merge_bytes(
        input logic [shell_pkg::data_w-1:0] old_word, new_word,
        input logic [shell_pkg::strb_w-1:0] strb);
        logic [shell_pkg::data_w-1:0] res;
        res = old_word;
        for (int b = 0; b < shell_pkg::strb_w; b++) begin
            if (strb[b])
                res[b*8 +: 8] = new_word[b*8 +: 8];
        end
        return res;
    endfunction

    function automatic logic [shell_pkg::addr_w-1:0] mem_addr(input int idx);
        return shell_pkg::mem_base + shell_pkg::addr_w'(idx * 8);
    endfunction

    // ------------------------------------------------------------------------
    // Memory window and voxel window tests
    // ------------------------------------------------------------------------
    task automatic test_mem_writes;
        logic [shell_pkg::addr_w-1:0] addr;
        logic [shell_pkg::data_w-1:0] data, rd;
        logic [shell_pkg::strb_w-1:0] strb;
        shell_pkg::resp_e             resp;
        int                           idx;
        repeat (16) begin
            idx  = $urandom_range(shell_pkg::mem_words - 1, 0);
            addr = mem_addr(idx);
            // Known background first, then a partial write on top
            mem_model[idx] = {4'h5, addr, 4'hA, ~addr};
            do_write(addr, mem_model[idx], '1, resp);
            check_resp(resp, shell_pkg::resp_okay, "memory fill response");
            data = {$urandom, $urandom};
            strb = shell_pkg::strb_w'($urandom);
            do_write(addr, data, strb, resp);
            check_resp(resp, shell_pkg::resp_okay, "memory write response");
            mem_model[idx] = merge_bytes(mem_model[idx], data, strb);
            do_read(addr, rd, resp);
            check_resp(resp, shell_pkg::resp_okay, "memory read response");
            check_data(rd, mem_model[idx], "memory read data");
            used_idx.push_back(idx);
        end
    endtask

    task automatic test_voxel_writes;
        logic [shell_pkg::voxel_idx_w-1:0] idx;
        logic [shell_pkg::data_w-1:0]      data, rd;
        logic [2:0]                        wr_off, rd_off;
        shell_pkg::resp_e                  resp;
        repeat (16) begin
            idx    = shell_pkg::voxel_idx_w'($urandom);
            data   = {$urandom, $urandom};
            wr_off = 3'($urandom);
            rd_off = wr_off ^ 3'($urandom_range(7, 1));
            do_write(shell_pkg::voxel_win_base + {idx, wr_off}, data, '1, resp);
            check_resp(resp, shell_pkg::resp_okay, "voxel write response");
            // Low byte offset differs from the write
            do_read(shell_pkg::voxel_win_base + {idx, rd_off}, rd, resp);
            check_resp(resp, shell_pkg::resp_okay, "voxel read response");
            check_data(rd, data, "voxel read data");
        end
    endtask

    task automatic test_out_of_range;
        logic [shell_pkg::addr_w-1:0] bad [2];
        logic [shell_pkg::data_w-1:0] rd;
        shell_pkg::resp_e             resp;
        int                           idx;
        idx    = used_idx[0];
        // Between the windows, then just past the end of the memory window
        bad[0] = 28'h080_0000 + shell_pkg::addr_w'(idx * 8);
        bad[1] = shell_pkg::mem_base + shell_pkg::mem_bytes + shell_pkg::addr_w'(idx * 8);
        foreach (bad[i]) begin
            do_write(bad[i], {$urandom, $urandom}, '1, resp);
            check_resp(resp, shell_pkg::resp_slverr, "out-of-range write response");
            do_read(bad[i], rd, resp);
            check_resp(resp, shell_pkg::resp_slverr, "out-of-range read response");
            check_data(rd, '0, "out-of-range read data");
        end
        do_read(mem_addr(idx), rd, resp);
        check_data(rd, mem_model[idx], "memory word after out-of-range writes");
    endtask

    task automatic test_write_backpressure;
        logic [shell_pkg::data_w-1:0] data_a, data_b, rd;
        shell_pkg::resp_e             resp;
        int                           idx_a, idx_b;
        idx_a  = used_idx[1];
        idx_b  = used_idx[2];
        data_a = {$urandom, $urandom};
        data_b = {$urandom, $urandom};
        b_ready <= 1'b0;
        drive_write(mem_addr(idx_a), data_a, '1);
        wait_write_accept();
        // Second write waits behind the stalled response
        drive_write(mem_addr(idx_b), data_b, '1);
        repeat ($urandom_range(8, 2)) begin
            @(posedge clk);
            if (!b_valid || wr_ready)
                report_failure("write response not held, or a second write taken, under stall");
        end
        b_ready <= 1'b1;
        wait_bresp(resp);
        check_resp(resp, shell_pkg::resp_okay, "stalled write response");
        wait_write_accept();
        wait_bresp(resp);
        check_resp(resp, shell_pkg::resp_okay, "queued write response");
        mem_model[idx_a] = data_a;
        mem_model[idx_b] = data_b;
        // Read-backs also stall on r_ready
        read_stall = $urandom_range(6, 2);
        do_read(mem_addr(idx_a), rd, resp);
        check_data(rd, mem_model[idx_a], "first word after stall");
        do_read(mem_addr(idx_b), rd, resp);
        check_data(rd, mem_model[idx_b], "second word after stall");
        read_stall = 0;
    endtask

    // ------------------------------------------------------------------------
    // Pixel stream
    // ------------------------------------------------------------------------
    task automatic check_stats;
        check_count(beat_count, exp_beats, "beat_count");
        check_count(frame_count, exp_frames, "frame_count");
        check_count(line_count, exp_lines, "line_count");
        check_count(pixel_in_line, exp_pil, "pixel_in_line");
    endtask

    task automatic send_pixel(input int addr);
        logic                        accepted;
        logic [shell_pkg::rgb_w-1:0] rgb;
        rgb       = shell_pkg::rgb_w'($urandom);
        pix_valid <= 1'b1;
        pix_addr  <= shell_pkg::pix_addr_w'(addr);
        pix_rgb   <= rgb;
        accepted  = 1'b0;
        while (!accepted) begin
            @(posedge clk);
            if (pix_ready !== tready || tvalid !== 1'b1)
                report_failure("pix_ready or tvalid does not follow the pixel input");
            check_count(tuser, addr == 0, "tuser");
            check_count(tlast, addr == shell_pkg::total_pixels - 1, "tlast");
            check_count(tdata, rgb, "tdata");
            check_stats();
            accepted = tready;
            tready   <= !stall_stream || ($urandom_range(2, 0) == 0);
        end
        exp_beats++;
        if (addr == 0) begin
            exp_pil   = 1;
            exp_lines = 0;
        end else begin
            exp_pil++;
            if (exp_pil == shell_pkg::screen_width) begin
                exp_pil = 0;
                exp_lines++;
            end
        end
        if (addr == shell_pkg::total_pixels - 1)
            exp_frames++;
    endtask

    task automatic test_frame_stats;
        stall_stream = 1'b0;
        for (int a = 0; a < 1000; a++)
            send_pixel(a);
        for (int a = shell_pkg::total_pixels - 1001; a < shell_pkg::total_pixels; a++)
            send_pixel(a);
        pix_valid <= 1'b0;
        @(posedge clk);
        check_stats();
    endtask

    task automatic test_stream_backpressure;
        stall_stream = 1'b1;
        // Runs across the end of one frame into the next
        for (int a = shell_pkg::total_pixels - 30; a < shell_pkg::total_pixels + 30; a++)
            send_pixel(a % shell_pkg::total_pixels);
        stall_stream = 1'b0;
        pix_valid <= 1'b0;
        tready    <= 1'b1;
        @(posedge clk);
        check_stats();
    endtask

    // ------------------------------------------------------------------------
    // Sequence and watchdog
    // ------------------------------------------------------------------------
    initial begin
        void'($urandom(38863));
        errors       = 0;
        read_stall   = 0;
        stall_stream = 1'b0;
        exp_beats    = 0;
        exp_frames   = 0;
        exp_lines    = 0;
        exp_pil      = 0;
        rst_n     <= 1'b0;
        wr_valid  <= 1'b0;
        wr_addr   <= '0;
        wr_data   <= '0;
        wr_strb   <= '0;
        b_ready   <= 1'b1;
        rd_valid  <= 1'b0;
        rd_addr   <= '0;
        r_ready   <= 1'b1;
        pix_valid <= 1'b0;
        pix_addr  <= '0;
        pix_rgb   <= '0;
        tready    <= 1'b1;
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);
        test_mem_writes();
        test_voxel_writes();
        test_out_of_range();
        test_write_backpressure();
        test_frame_stats();
        test_stream_backpressure();
        $display("Check errors: %0d, assertion errors: %0d", errors,
                 dut_i.router_i.props_i.fail_count);
        if (errors == 0 && dut_i.router_i.props_i.fail_count == 0)
            $display(">>> PASS");
        else
            $display(">>> FAIL");
        $finish;
    end

    initial begin
        repeat (2 * test_cycles + 1000) @(posedge clk);
        $display("Run timed out: the tests did not finish within %0d cycles",
                 2 * test_cycles + 1000);
        $display(">>> FAIL");
        $finish;
    end

endmodule

// File: sources.f
shell_pkg.sv
mem_stub.sv
voxel_window_store.sv
ext_port_router.sv
pixel_stream_monitor.sv
voxel_shell_top.sv
voxel_shell_props.sv
voxel_shell_tb.sv
